// File: design/rv_core.sv
`default_nettype none

module rv_core (
  input  wire logic                         clk_i,
  input  wire logic                         rst_n_i,
  input  wire logic [31:0]                  imem_data_i,
  output logic [rv_core_pkg::XLEN-1:0]      imem_addr_o,
  output logic                              retire_valid_o,
  output logic [rv_core_pkg::XLEN-1:0]      retire_pc_o,
  output logic [rv_core_pkg::REG_BITS-1:0]  retire_rd_o,
  output logic [rv_core_pkg::XLEN-1:0]      retire_data_o
);

  import rv_core_pkg::*;

  // Fetch register
  logic                f_valid;
  logic [XLEN-1:0]     f_pc;
  logic [31:0]         f_instr;

  // Decode and register file
  logic [REG_BITS-1:0] rs1_addr;
  logic [REG_BITS-1:0] rs2_addr;
  logic [XLEN-1:0]     rs1_data;
  logic [XLEN-1:0]     rs2_data;
  dec_pl_t             dec_pl;
  logic                dec_legal;

  // Execute
  logic                x_valid;
  dec_pl_t             x_pl;
  logic                ex_valid;
  wb_pl_t              ex_pl;
  logic                redirect;
  logic [XLEN-1:0]     redirect_pc;

  // Writeback to register file and forwarding
  logic                rf_we;
  logic [REG_BITS-1:0] rf_waddr;
  logic [XLEN-1:0]     rf_wdata;

  ////////////////////////////////
  // Front end
  ////////////////////////////////

  rv_fetch u_fetch (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .redirect_i    (redirect),
    .redirect_pc_i (redirect_pc),
    .imem_data_i   (imem_data_i),
    .imem_addr_o   (imem_addr_o),
    .f_valid_o     (f_valid),
    .f_pc_o        (f_pc),
    .f_instr_o     (f_instr)
  );

  rv_decode u_decode (
    .f_valid_i  (f_valid),
    .f_pc_i     (f_pc),
    .f_instr_i  (f_instr),
    .rs1_data_i (rs1_data),
    .rs2_data_i (rs2_data),
    .rs1_addr_o (rs1_addr),
    .rs2_addr_o (rs2_addr),
    .pl_o       (dec_pl),
    .legal_o    (dec_legal)
  );

  rv_regfile u_regfile (
    .clk_i    (clk_i),
    .rst_n_i  (rst_n_i),
    .we_i     (rf_we),
    .waddr_i  (rf_waddr),
    .wdata_i  (rf_wdata),
    .raddr1_i (rs1_addr),
    .raddr2_i (rs2_addr),
    .rdata1_o (rs1_data),
    .rdata2_o (rs2_data)
  );

  ////////////////////////////////
  // Back end
  ////////////////////////////////

  // Redirect drops the instruction behind the branch
  rv_stage_reg #(
    .T       (dec_pl_t)
  ) u_dx_reg (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .flush_i (redirect),
    .valid_i (dec_legal),
    .pl_i    (dec_pl),
    .valid_o (x_valid),
    .pl_o    (x_pl)
  );

  rv_execute u_execute (
    .x_valid_i     (x_valid),
    .x_pl_i        (x_pl),
    .wb_valid_i    (rf_we),
    .wb_rd_i       (rf_waddr),
    .wb_data_i     (rf_wdata),
    .valid_o       (ex_valid),
    .pl_o          (ex_pl),
    .redirect_o    (redirect),
    .redirect_pc_o (redirect_pc)
  );

  rv_writeback u_writeback (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .valid_i        (ex_valid),
    .pl_i           (ex_pl),
    .rf_we_o        (rf_we),
    .rf_waddr_o     (rf_waddr),
    .rf_wdata_o     (rf_wdata),
    .retire_valid_o (retire_valid_o),
    .retire_pc_o    (retire_pc_o),
    .retire_rd_o    (retire_rd_o),
    .retire_data_o  (retire_data_o)
  );

endmodule

`default_nettype wire

// File: design/rv_core_pkg.sv
`default_nettype none

package rv_core_pkg;

  localparam int XLEN     = 32;
  localparam int REG_BITS = 5;

  // First fetch address out of reset
  localparam logic [XLEN-1:0] RESET_PC = 32'h0000_0000;

  ////////////////////////////////
  // Stage payloads
  ////////////////////////////////

  // Decode to execute
  typedef struct packed {
    logic [XLEN-1:0]     pc;
    logic [REG_BITS-1:0] rd;
    logic [REG_BITS-1:0] rs1;
    logic [REG_BITS-1:0] rs2;
    logic [XLEN-1:0]     rs1_val;
    logic [XLEN-1:0]     rs2_val;
    logic [XLEN-1:0]     imm;
    rv_isa_pkg::alu_op_e alu_op;
    // Operand A is the pc
    logic                use_pc;
    // Operand B is the immediate
    logic                use_imm;
    logic                is_branch;
    logic                is_jal;
    rv_isa_pkg::br_cond_e br_cond;
  } dec_pl_t;

  // Execute to writeback
  typedef struct packed {
    logic [XLEN-1:0]     pc;
    logic [REG_BITS-1:0] rd;
    logic [XLEN-1:0]     result;
  } wb_pl_t;

endpackage

`default_nettype wire

// File: design/rv_decode.sv
`default_nettype none

module rv_decode (
  input  wire logic                             f_valid_i,
  input  wire logic [rv_core_pkg::XLEN-1:0]     f_pc_i,
  input  wire logic [31:0]                      f_instr_i,
  input  wire logic [rv_core_pkg::XLEN-1:0]     rs1_data_i,
  input  wire logic [rv_core_pkg::XLEN-1:0]     rs2_data_i,
  output logic [rv_core_pkg::REG_BITS-1:0]      rs1_addr_o,
  output logic [rv_core_pkg::REG_BITS-1:0]      rs2_addr_o,
  output rv_core_pkg::dec_pl_t                  pl_o,
  output logic                                  legal_o
);

  import rv_isa_pkg::*;
  import rv_core_pkg::*;

  logic [31:0]         instr;
  logic [2:0]          funct3;
  logic [6:0]          funct7;
  logic [XLEN-1:0]     imm_i;
  logic [XLEN-1:0]     imm_b;
  logic [XLEN-1:0]     imm_u;
  logic [XLEN-1:0]     imm_j;
  logic [REG_BITS-1:0] rd_sel;
  logic [REG_BITS-1:0] rs1_sel;
  logic [REG_BITS-1:0] rs2_sel;
  logic [XLEN-1:0]     imm;
  alu_op_e             alu_op;
  logic                use_pc;
  logic                use_imm;
  logic                is_branch;
  logic                is_jal;
  logic                legal;

  // Empty slot decodes as a NOP
  assign instr  = f_valid_i ? f_instr_i : INSTR_NOP;
  assign funct3 = instr[14:12];
  assign funct7 = instr[31:25];

  ////////////////////////////////
  // Immediate formats
  ////////////////////////////////

  assign imm_i = {{20{instr[31]}}, instr[31:20]};
  assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
  assign imm_u = {instr[31:12], 12'b0};
  assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

  // funct3 to ALU op, alt picks SUB or SRA
  function automatic alu_op_e alu_from_f3(input logic [2:0] f3, input logic alt);
    case (f3)
      F3_ADD:  return alt ? ALU_SUB : ALU_ADD;
      F3_SLL:  return ALU_SLL;
      F3_SLT:  return ALU_SLT;
      F3_SLTU: return ALU_SLTU;
      F3_XOR:  return ALU_XOR;
      F3_SR:   return alt ? ALU_SRA : ALU_SRL;
      F3_OR:   return ALU_OR;
      default: return ALU_AND;
    endcase
  endfunction

  always_comb begin
    rd_sel    = instr[11:7];
    rs1_sel   = instr[19:15];
    rs2_sel   = instr[24:20];
    imm       = imm_i;
    alu_op    = ALU_ADD;
    use_pc    = 1'b0;
    use_imm   = 1'b0;
    is_branch = 1'b0;
    is_jal    = 1'b0;
    legal     = 1'b0;
    case (opcode_e'(instr[6:0]))
      OPC_LUI: begin
        legal   = 1'b1;
        imm     = imm_u;
        use_imm = 1'b1;
        alu_op  = ALU_PASS_B;
        rs1_sel = '0;
        rs2_sel = '0;
      end
      OPC_AUIPC: begin
        legal   = 1'b1;
        imm     = imm_u;
        use_imm = 1'b1;
        use_pc  = 1'b1;
        rs1_sel = '0;
        rs2_sel = '0;
      end
      OPC_JAL: begin
        // Result is pc+4, formed in execute
        legal   = 1'b1;
        imm     = imm_j;
        is_jal  = 1'b1;
        rs1_sel = '0;
        rs2_sel = '0;
      end
      OPC_BRANCH: begin
        // funct3 010 and 011 are unassigned
        legal     = (funct3 != 3'b010) && (funct3 != 3'b011);
        imm       = imm_b;
        is_branch = 1'b1;
        rd_sel    = '0;
      end
      OPC_OP_IMM: begin
        use_imm = 1'b1;
        rs2_sel = '0;
        // Bit 30 is an immediate bit except on shift right
        alu_op  = alu_from_f3(funct3, (funct3 == F3_SR) && instr[30]);
        case (funct3)
          F3_SLL:  legal = (funct7 == F7_BASE);
          F3_SR:   legal = (funct7 == F7_BASE) || (funct7 == F7_ALT);
          default: legal = 1'b1;
        endcase
      end
      OPC_OP: begin
        alu_op = alu_from_f3(funct3, instr[30]);
        legal  = (funct7 == F7_BASE) ||
                 ((funct7 == F7_ALT) && ((funct3 == F3_ADD) || (funct3 == F3_SR)));
      end
      default: legal = 1'b0;
    endcase
  end

  // Register file is read by the masked addresses
  assign rs1_addr_o = rs1_sel;
  assign rs2_addr_o = rs2_sel;

  // Undecodable or empty slot becomes a bubble
  assign legal_o = f_valid_i && legal;

  always_comb begin
    pl_o.pc        = f_pc_i;
    pl_o.rd        = rd_sel;
    pl_o.rs1       = rs1_sel;
    pl_o.rs2       = rs2_sel;
    pl_o.rs1_val   = rs1_data_i;
    pl_o.rs2_val   = rs2_data_i;
    pl_o.imm       = imm;
    pl_o.alu_op    = alu_op;
    pl_o.use_pc    = use_pc;
    pl_o.use_imm   = use_imm;
    pl_o.is_branch = is_branch;
    pl_o.is_jal    = is_jal;
    pl_o.br_cond   = br_cond_e'(funct3);
  end

endmodule

`default_nettype wire

// File: design/rv_execute.sv
`default_nettype none

module rv_execute (
  input  wire logic                             x_valid_i,
  input  wire rv_core_pkg::dec_pl_t             x_pl_i,
  input  wire logic                             wb_valid_i,
  input  wire logic [rv_core_pkg::REG_BITS-1:0] wb_rd_i,
  input  wire logic [rv_core_pkg::XLEN-1:0]     wb_data_i,
  output logic                                  valid_o,
  output rv_core_pkg::wb_pl_t                   pl_o,
  output logic                                  redirect_o,
  output logic [rv_core_pkg::XLEN-1:0]          redirect_pc_o
);

  import rv_isa_pkg::*;
  import rv_core_pkg::*;

  logic [XLEN-1:0] rs1_val;
  logic [XLEN-1:0] rs2_val;
  logic [XLEN-1:0] op_a;
  logic [XLEN-1:0] op_b;
  logic [XLEN-1:0] alu_out;
  logic [4:0]      shamt;
  logic            taken;

  ////////////////////////////////
  // Operand forwarding
  ////////////////////////////////

  // Writeback result is younger than the decode-time read
  assign rs1_val = (wb_valid_i && (wb_rd_i != '0) && (wb_rd_i == x_pl_i.rs1)) ?
                   wb_data_i : x_pl_i.rs1_val;
  assign rs2_val = (wb_valid_i && (wb_rd_i != '0) && (wb_rd_i == x_pl_i.rs2)) ?
                   wb_data_i : x_pl_i.rs2_val;

  assign op_a  = x_pl_i.use_pc ? x_pl_i.pc : rs1_val;
  assign op_b  = x_pl_i.use_imm ? x_pl_i.imm : rs2_val;
  assign shamt = op_b[4:0];

  ////////////////////////////////
  // ALU and branch compare
  ////////////////////////////////

  always_comb begin
    case (x_pl_i.alu_op)
      ALU_ADD:  alu_out = op_a + op_b;
      ALU_SUB:  alu_out = op_a - op_b;
      ALU_SLL:  alu_out = op_a << shamt;
      ALU_SLT:  alu_out = XLEN'($signed(op_a) < $signed(op_b));
      ALU_SLTU: alu_out = XLEN'(op_a < op_b);
      ALU_XOR:  alu_out = op_a ^ op_b;
      ALU_SRL:  alu_out = op_a >> shamt;
      ALU_SRA:  alu_out = $unsigned($signed(op_a) >>> shamt);
      ALU_OR:   alu_out = op_a | op_b;
      ALU_AND:  alu_out = op_a & op_b;
      default:  alu_out = op_b;
    endcase
  end

  // Always on the forwarded register values
  always_comb begin
    case (x_pl_i.br_cond)
      BR_BEQ:  taken = (rs1_val == rs2_val);
      BR_BNE:  taken = (rs1_val != rs2_val);
      BR_BLT:  taken = ($signed(rs1_val) < $signed(rs2_val));
      BR_BGE:  taken = ($signed(rs1_val) >= $signed(rs2_val));
      BR_BLTU: taken = (rs1_val < rs2_val);
      default: taken = (rs1_val >= rs2_val);
    endcase
  end

  // JAL and taken branch steer fetch
  assign redirect_o    = x_valid_i && (x_pl_i.is_jal || (x_pl_i.is_branch && taken));
  assign redirect_pc_o = x_pl_i.pc + x_pl_i.imm;

  // Redirecting instruction itself still retires
  assign valid_o       = x_valid_i;
  assign pl_o.pc       = x_pl_i.pc;
  assign pl_o.rd       = x_pl_i.rd;
  assign pl_o.result   = x_pl_i.is_jal ? x_pl_i.pc + XLEN'(4) : alu_out;

endmodule

`default_nettype wire

// File: design/rv_fetch.sv
`default_nettype none

module rv_fetch (
  input  wire logic                         clk_i,
  input  wire logic                         rst_n_i,
  input  wire logic                         redirect_i,
  input  wire logic [rv_core_pkg::XLEN-1:0] redirect_pc_i,
  input  wire logic [31:0]                  imem_data_i,
  output logic [rv_core_pkg::XLEN-1:0]      imem_addr_o,
  output logic                              f_valid_o,
  output logic [rv_core_pkg::XLEN-1:0]      f_pc_o,
  output logic [31:0]                       f_instr_o
);

  import rv_core_pkg::*;

  logic [XLEN-1:0] pc_q;
  logic [XLEN-1:0] pc_next;

  // Redirect target wins over sequential fetch
  assign pc_next = redirect_i ? redirect_pc_i : pc_q + XLEN'(4);

  // Memory answers in the same cycle
  assign imem_addr_o = pc_q;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      pc_q      <= RESET_PC;
      f_valid_o <= 1'b0;
    end else begin
      pc_q      <= pc_next;
      // Word fetched beside a redirect is on the wrong path
      f_valid_o <= !redirect_i;
    end
  end

  // Fetch register payload
  always_ff @(posedge clk_i) begin
    f_instr_o <= imem_data_i;
    f_pc_o    <= pc_q;
  end

  // Sequential and redirect paths both keep word alignment
  pc_aligned_a : assert property (
    @(posedge clk_i) disable iff (!rst_n_i) pc_q[1:0] == 2'b00
  );

endmodule

`default_nettype wire

// File: design/rv_isa_pkg.sv
`default_nettype none

package rv_isa_pkg;

  ////////////////////////////////
  // Major opcodes
  ////////////////////////////////

  // Only the groups this core executes
  typedef enum logic [6:0] {
    OPC_LUI    = 7'b0110111,
    OPC_AUIPC  = 7'b0010111,
    OPC_JAL    = 7'b1101111,
    OPC_BRANCH = 7'b1100011,
    OPC_OP_IMM = 7'b0010011,
    OPC_OP     = 7'b0110011
  } opcode_e;

  // funct3 of the OP and OP-IMM groups
  localparam logic [2:0] F3_ADD  = 3'b000;
  localparam logic [2:0] F3_SLL  = 3'b001;
  localparam logic [2:0] F3_SLT  = 3'b010;
  localparam logic [2:0] F3_SLTU = 3'b011;
  localparam logic [2:0] F3_XOR  = 3'b100;
  localparam logic [2:0] F3_SR   = 3'b101;
  localparam logic [2:0] F3_OR   = 3'b110;
  localparam logic [2:0] F3_AND  = 3'b111;

  // funct7 values, the alternate one selects SUB and SRA
  localparam logic [6:0] F7_BASE = 7'b0000000;
  localparam logic [6:0] F7_ALT  = 7'b0100000;

  ////////////////////////////////
  // Execute operations
  ////////////////////////////////

  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_SLL,
    ALU_SLT,
    ALU_SLTU,
    ALU_XOR,
    ALU_SRL,
    ALU_SRA,
    ALU_OR,
    ALU_AND,
    ALU_PASS_B
  } alu_op_e;

  // Encoded exactly as the branch funct3
  typedef enum logic [2:0] {
    BR_BEQ  = 3'b000,
    BR_BNE  = 3'b001,
    BR_BLT  = 3'b100,
    BR_BGE  = 3'b101,
    BR_BLTU = 3'b110,
    BR_BGEU = 3'b111
  } br_cond_e;

  // addi x0, x0, 0
  localparam logic [31:0] INSTR_NOP = 32'h0000_0013;

endpackage

`default_nettype wire

// File: design/rv_regfile.sv
`default_nettype none

module rv_regfile (
  input  wire logic                             clk_i,
  input  wire logic                             rst_n_i,
  input  wire logic                             we_i,
  input  wire logic [rv_core_pkg::REG_BITS-1:0] waddr_i,
  input  wire logic [rv_core_pkg::XLEN-1:0]     wdata_i,
  input  wire logic [rv_core_pkg::REG_BITS-1:0] raddr1_i,
  input  wire logic [rv_core_pkg::REG_BITS-1:0] raddr2_i,
  output logic [rv_core_pkg::XLEN-1:0]          rdata1_o,
  output logic [rv_core_pkg::XLEN-1:0]          rdata2_o
);

  import rv_core_pkg::*;

  // x0 has no storage
  logic [XLEN-1:0] regs [1:31];

  always_ff @(posedge clk_i) begin
    if (we_i && (waddr_i != '0)) begin
      regs[waddr_i] <= wdata_i;
    end
  end

  // Same-cycle write passes straight through
  function automatic logic [XLEN-1:0] read_port(input logic [REG_BITS-1:0] addr);
    if (addr == '0) begin
      return '0;
    end
    if (we_i && (waddr_i == addr)) begin
      return wdata_i;
    end
    return regs[addr];
  endfunction

  assign rdata1_o = read_port(raddr1_i);
  assign rdata2_o = read_port(raddr2_i);

  // Writeback filters rd 0 before asking for a write
  no_x0_write_a : assert property (
    @(posedge clk_i) disable iff (!rst_n_i) we_i |-> (waddr_i != '0)
  );

endmodule

`default_nettype wire

// File: design/rv_stage_reg.sv
`default_nettype none

module rv_stage_reg #(
  parameter type T = rv_core_pkg::wb_pl_t
) (
  input  wire logic clk_i,
  input  wire logic rst_n_i,
  input  wire logic flush_i,
  input  wire logic valid_i,
  input  wire T     pl_i,
  output logic      valid_o,
  output T          pl_o
);

  // Valid level, cleared by reset or a flush
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      valid_o <= 1'b0;
    end else if (flush_i) begin
      valid_o <= 1'b0;
    end else begin
      valid_o <= valid_i;
    end
  end

  // Payload follows every cycle, meaningful only when valid
  always_ff @(posedge clk_i) begin
    pl_o <= pl_i;
  end

  // Upstream valids must all be resolved after reset
  valid_known_a : assert property (
    @(posedge clk_i) disable iff (!rst_n_i) !$isunknown(valid_o)
  );

endmodule

`default_nettype wire

// File: design/rv_writeback.sv
`default_nettype none

module rv_writeback (
  input  wire logic                         clk_i,
  input  wire logic                         rst_n_i,
  input  wire logic                         valid_i,
  input  wire rv_core_pkg::wb_pl_t          pl_i,
  output logic                              rf_we_o,
  output logic [rv_core_pkg::REG_BITS-1:0]  rf_waddr_o,
  output logic [rv_core_pkg::XLEN-1:0]      rf_wdata_o,
  output logic                              retire_valid_o,
  output logic [rv_core_pkg::XLEN-1:0]      retire_pc_o,
  output logic [rv_core_pkg::REG_BITS-1:0]  retire_rd_o,
  output logic [rv_core_pkg::XLEN-1:0]      retire_data_o
);

  import rv_core_pkg::*;

  logic   wb_valid;
  wb_pl_t wb_pl;
  logic   has_rd;

  // Nothing downstream can cancel a finished instruction
  rv_stage_reg #(
    .T       (wb_pl_t)
  ) u_wb_reg (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .flush_i (1'b0),
    .valid_i (valid_i),
    .pl_i    (pl_i),
    .valid_o (wb_valid),
    .pl_o    (wb_pl)
  );

  assign has_rd = (wb_pl.rd != '0);

  // Register write, also the forwarding source
  assign rf_we_o    = wb_valid && has_rd;
  assign rf_waddr_o = wb_pl.rd;
  assign rf_wdata_o = wb_pl.result;

  // Retire port, one cycle per instruction
  assign retire_valid_o = wb_valid;
  assign retire_pc_o    = wb_pl.pc;
  assign retire_rd_o    = wb_pl.rd;
  assign retire_data_o  = has_rd ? wb_pl.result : '0;

endmodule

`default_nettype wire

// File: files.f
+incdir+tb
design/rv_isa_pkg.sv
design/rv_core_pkg.sv
design/rv_stage_reg.sv
design/rv_fetch.sv
design/rv_decode.sv
design/rv_regfile.sv
design/rv_execute.sv
design/rv_writeback.sv
design/rv_core.sv
tb/rv_core_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build the core testbench with Verilator, run it and scan the log.
set -eo pipefail

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert \
  --top-module rv_core_tb \
  -f files.f \
  -o rv_core_sim

./obj_dir/rv_core_sim | tee sim.log

if grep -q "sim failed" sim.log; then
  echo "run_sim.sh: failure reported in sim.log"
  exit 1
fi
echo "run_sim.sh: no failure reported"

// File: tb/rv_ref_model.svh
`ifndef RV_REF_MODEL_SVH
`define RV_REF_MODEL_SVH

////////////////////////////////
// Program memory
////////////////////////////////

localparam int              PROG_WORDS   = 160;
localparam int              IDX_BITS     = $clog2(PROG_WORDS);
localparam logic [XLEN-1:0] PROG_BYTES   = XLEN'(PROG_WORDS * 4);
// jal x0, 0 spins on its own address
localparam logic [31:0]     SELF_JAL     = 32'h0000_006f;
localparam int              TAIL_RETIRES = 4;

localparam logic [2:0] BRANCH_F3 [6] = '{3'b000, 3'b001, 3'b100, 3'b101, 3'b110, 3'b111};

logic [31:0]     prog_mem [PROG_WORDS];
logic [XLEN-1:0] ref_regs [32];
logic [XLEN-1:0] ref_pc;

// Past the program every word is a spin loop
function automatic logic [31:0] mem_word(input logic [XLEN-1:0] addr);
  if (addr < PROG_BYTES) begin
    return prog_mem[addr[IDX_BITS+1:2]];
  end
  return SELF_JAL;
endfunction

// Encoders for the formats the core runs
function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] rs2,
                                       input logic [4:0] rs1, input logic [2:0] f3,
                                       input logic [4:0] rd);
  return {f7, rs2, rs1, f3, rd, OPC_OP};
endfunction

function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [4:0] rs1,
                                       input logic [2:0] f3, input logic [4:0] rd);
  return {imm, rs1, f3, rd, OPC_OP_IMM};
endfunction

function automatic logic [31:0] u_type(input logic [19:0] imm, input logic [4:0] rd,
                                       input logic [6:0] opc);
  return {imm, rd, opc};
endfunction

function automatic logic [31:0] b_type(input logic [12:0] off, input logic [4:0] rs2,
                                       input logic [4:0] rs1, input logic [2:0] f3);
  return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], OPC_BRANCH};
endfunction

function automatic logic [31:0] j_type(input logic [20:0] off, input logic [4:0] rd);
  return {off[20], off[10:1], off[11], off[19:12], rd, OPC_JAL};
endfunction

// Small pool, so dependencies at distance one and two are common
function automatic logic [REG_BITS-1:0] pick_reg();
  return REG_BITS'($urandom_range(0, 7));
endfunction

task automatic build_program();
  int          kind;
  logic [2:0]  f3;
  logic [6:0]  f7;
  logic [11:0] imm;
  logic [4:0]  rs1;
  logic [4:0]  rs2;
  // Prologue gives x1..x7 known values before any read
  for (int k = 1; k < 8; k++) begin
    if (k < 4) begin
      prog_mem[k-1] = u_type(20'($urandom), 5'(k), OPC_LUI);
    end else begin
      prog_mem[k-1] = i_type(12'($urandom), 5'd0, 3'b000, 5'(k));
    end
  end
  for (int i = 7; i < PROG_WORDS; i++) begin
    kind = int'($urandom_range(0, 99));
    f3   = 3'($urandom);
    rs1  = pick_reg();
    rs2  = pick_reg();
    if (kind < 35) begin
      // Alternate funct7 only exists for SUB and SRA
      f7 = ((f3 == 3'b000 || f3 == 3'b101) && $urandom_range(0, 1) == 1) ? F7_ALT : F7_BASE;
      prog_mem[i] = r_type(f7, rs2, rs1, f3, pick_reg());
    end else if (kind < 65) begin
      imm = 12'($urandom);
      if (f3 == 3'b001) begin
        imm = {F7_BASE, imm[4:0]};
      end else if (f3 == 3'b101) begin
        imm = {imm[10] ? F7_ALT : F7_BASE, imm[4:0]};
      end
      prog_mem[i] = i_type(imm, rs1, f3, pick_reg());
    end else if (kind < 73) begin
      prog_mem[i] = u_type(20'($urandom), pick_reg(), OPC_LUI);
    end else if (kind < 78) begin
      prog_mem[i] = u_type(20'($urandom), pick_reg(), OPC_AUIPC);
    end else if (kind < 93) begin
      // Same register on both sides hits the equal case
      if ($urandom_range(0, 3) == 0) begin
        rs2 = rs1;
      end
      f3 = BRANCH_F3[int'($urandom_range(0, 5))];
      prog_mem[i] = b_type(13'(4 * $urandom_range(2, 4)), rs2, rs1, f3);
    end else begin
      prog_mem[i] = j_type(21'(4 * $urandom_range(2, 4)), pick_reg());
    end
  end
endtask

////////////////////////////////
// ISA reference
////////////////////////////////

function automatic logic [XLEN-1:0] alu_ref(input logic [2:0] f3, input logic alt,
                                            input logic [XLEN-1:0] a,
                                            input logic [XLEN-1:0] b);
  case (f3)
    3'b000:  return alt ? a - b : a + b;
    3'b001:  return a << b[4:0];
    3'b010:  return {{(XLEN-1){1'b0}}, $signed(a) < $signed(b)};
    3'b011:  return {{(XLEN-1){1'b0}}, a < b};
    3'b100:  return a ^ b;
    3'b101:  return alt ? $unsigned($signed(a) >>> b[4:0]) : a >> b[4:0];
    3'b110:  return a | b;
    default: return a & b;
  endcase
endfunction

// One instruction on the model state, returns what should retire
function automatic void rv_ref_step(output logic [XLEN-1:0] exp_pc,
                                    output logic [REG_BITS-1:0] exp_rd,
                                    output logic [XLEN-1:0] exp_data);
  logic [31:0]         instr;
  logic [2:0]          f3;
  logic [REG_BITS-1:0] rd;
  logic [XLEN-1:0]     a;
  logic [XLEN-1:0]     b;
  logic [XLEN-1:0]     imm_i;
  logic [XLEN-1:0]     imm_b;
  logic [XLEN-1:0]     imm_j;
  logic [XLEN-1:0]     res;
  logic [XLEN-1:0]     next_pc;
  logic                take;
  instr   = mem_word(ref_pc);
  f3      = instr[14:12];
  rd      = instr[11:7];
  a       = ref_regs[instr[19:15]];
  b       = ref_regs[instr[24:20]];
  imm_i   = {{20{instr[31]}}, instr[31:20]};
  imm_b   = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
  imm_j   = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
  res     = '0;
  take    = 1'b0;
  next_pc = ref_pc + 32'd4;
  case (instr[6:0])
    OPC_LUI:    res = {instr[31:12], 12'h000};
    OPC_AUIPC:  res = ref_pc + {instr[31:12], 12'h000};
    OPC_JAL: begin
      res     = ref_pc + 32'd4;
      next_pc = ref_pc + imm_j;
    end
    OPC_BRANCH: begin
      // Branches have no destination
      rd = '0;
      case (f3)
        3'b000:  take = (a == b);
        3'b001:  take = (a != b);
        3'b100:  take = ($signed(a) < $signed(b));
        3'b101:  take = ($signed(a) >= $signed(b));
        3'b110:  take = (a < b);
        3'b111:  take = (a >= b);
        default: take = 1'b0;
      endcase
      if (take) begin
        next_pc = ref_pc + imm_b;
      end
    end
    OPC_OP_IMM: res = alu_ref(f3, (f3 == 3'b101) && instr[30], a, imm_i);
    OPC_OP:     res = alu_ref(f3, instr[30], a, b);
    default:    res = '0;
  endcase
  if (rd == '0) begin
    res = '0;
  end else begin
    ref_regs[rd] = res;
  end
  exp_pc   = ref_pc;
  exp_rd   = rd;
  exp_data = res;
  ref_pc   = next_pc;
endfunction

`endif

// File: tb/rv_core_tb.sv
`default_nettype none

module rv_core_tb;

  import rv_isa_pkg::*;
  import rv_core_pkg::*;

  localparam int CLK_HALF     = 10;
  localparam int RESET_CYCLES = 10;
  localparam int DRIVE_DELAY  = 2;

  logic                clk_i;
  logic                rst_n_i;
  logic [31:0]         imem_data_i;
  logic [XLEN-1:0]     imem_addr_o;
  logic                retire_valid_o;
  logic [XLEN-1:0]     retire_pc_o;
  logic [REG_BITS-1:0] retire_rd_o;
  logic [XLEN-1:0]     retire_data_o;

  // Expected retire stream, in program order
  logic [XLEN-1:0]     exp_pc_q   [$];
  logic [REG_BITS-1:0] exp_rd_q   [$];
  logic [XLEN-1:0]     exp_data_q [$];

  int value_errors = 0;
  int other_errors = 0;
  int retired      = 0;
  bit checks_done  = 1'b0;

  `include "rv_ref_model.svh"

  rv_core dut_i (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .imem_data_i    (imem_data_i),
    .imem_addr_o    (imem_addr_o),
    .retire_valid_o (retire_valid_o),
    .retire_pc_o    (retire_pc_o),
    .retire_rd_o    (retire_rd_o),
    .retire_data_o  (retire_data_o)
  );

  // Memory answers in the same cycle
  always_comb imem_data_i = mem_word(imem_addr_o);

  initial begin : clock_gen
    clk_i = 1'b0;
    forever #CLK_HALF clk_i = ~clk_i;
  end

  // Model run until the pc leaves the program, plus a few spin retires
  task automatic build_expected();
    logic [XLEN-1:0]     pc;
    logic [REG_BITS-1:0] rd;
    logic [XLEN-1:0]     data;
    int                  tail;
    ref_pc = RESET_PC;
    tail   = 0;
    foreach (ref_regs[r]) begin
      ref_regs[r] = '0;
    end
    while (tail < TAIL_RETIRES) begin
      if (ref_pc >= PROG_BYTES) begin
        tail++;
      end
      rv_ref_step(pc, rd, data);
      exp_pc_q.push_back(pc);
      exp_rd_q.push_back(rd);
      exp_data_q.push_back(data);
    end
  endtask

  ////////////////////////////////
  // Compare tasks
  ////////////////////////////////

  task automatic check_pc(input logic [XLEN-1:0] got, input logic [XLEN-1:0] exp);
    if (got !== exp) begin
      $display("Error: retire_pc_o = %h, expected %h (retire %0d)", got, exp, retired);
      value_errors++;
    end
  endtask

  task automatic check_rd(input logic [REG_BITS-1:0] got, input logic [REG_BITS-1:0] exp);
    if (got !== exp) begin
      $display("Error: retire_rd_o = %h, expected %h (retire %0d)", got, exp, retired);
      value_errors++;
    end
  endtask

  task automatic check_data(input logic [XLEN-1:0] got, input logic [XLEN-1:0] exp);
    if (got !== exp) begin
      $display("Error: retire_data_o = %h, expected %h (retire %0d)", got, exp, retired);
      value_errors++;
    end
  endtask

  // Retire outputs are registered, so the falling edge sees them settled
  initial begin : retire_checker
    forever begin
      @(negedge clk_i);
      if (!rst_n_i) begin
        if (retire_valid_o !== 1'b0) begin
          $display("Retire port is active while reset is asserted");
          other_errors++;
        end
      end else if ($isunknown(retire_valid_o)) begin
        $display("Retire valid is unknown after reset");
        other_errors++;
      end else if (retire_valid_o && !checks_done) begin
        check_pc(retire_pc_o, exp_pc_q[retired]);
        check_rd(retire_rd_o, exp_rd_q[retired]);
        check_data(retire_data_o, exp_data_q[retired]);
        retired++;
        if (retired == exp_pc_q.size()) begin
          checks_done = 1'b1;
        end
      end
    end
  end

  // Taken redirects cost three cycles per retire at worst
  initial begin : watchdog
    repeat ((PROG_WORDS + 50) * 4) @(posedge clk_i);
    $display("Timeout: only %0d of %0d expected retires seen", retired, exp_pc_q.size());
    $display("sim failed");
    $finish;
  end

  initial begin : run_test
    rst_n_i = 1'b0;
    void'($urandom(32'h7341));
    build_program();
    build_expected();
    $display("Program of %0d words, %0d retires expected", PROG_WORDS, exp_pc_q.size());
    repeat (RESET_CYCLES) @(posedge clk_i);
    #DRIVE_DELAY;
    rst_n_i = 1'b1;
    wait (checks_done);
    repeat (2) @(posedge clk_i);
    $display("Retired %0d, value errors %0d, other errors %0d",
             retired, value_errors, other_errors);
    if (value_errors + other_errors == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

`default_nettype wire
